// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;  // register / memory data
  typedef logic [xlen-1:0] pc_t;    // byte address
  typedef logic [xlen-1:0] inst_t;  // raw instruction
  typedef logic [4:0]      reg_idx_t;

  localparam int dmem_depth = 256;   // data words
  typedef logic [7:0] dmem_addr_t;   // word index into dmem

  localparam reg_idx_t ecall_arg_reg = 5'd17;  // a7
  localparam word_t    halt_code     = 32'd10;  // exit service

  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  // coarse class from decode, refined in execute
  typedef enum logic [1:0] {mode_add, mode_reg, mode_imm, mode_branch} alu_mode_e;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4} wb_sel_e;

  typedef enum logic [1:0] {jump_none, jump_branch, jump_jal, jump_jalr} jump_e;

  typedef struct packed {
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      alu_src;    // 1: imm as operand b
    alu_mode_e alu_mode;
    wb_sel_e   wb_sel;
    jump_e     jump;
    logic      is_ecall;
  } ctrl_t;

  typedef struct packed {
    inst_t inst;
    pc_t   pc;
  } if_id_t;

  typedef struct packed {
    ctrl_t      ctrl;
    pc_t        pc;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic [2:0] funct3;
    logic       funct7;    // inst[30]
  } id_ex_t;

  typedef struct packed {
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    wb_sel_e  wb_sel;
    logic     halt;
    word_t    alu_out;
    word_t    store_data;
    reg_idx_t rd;
    pc_t      pc;
  } ex_mem_t;

  typedef struct packed {
    logic     reg_write;
    wb_sel_e  wb_sel;
    logic     halt;
    word_t    alu_out;
    word_t    mem_data;
    reg_idx_t rd;
    pc_t      pc;
  } mem_wb_t;

endpackage

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
  input  logic             clk,
  input  logic             reset,
  input  logic             stall,
  input  logic             redirect,
  input  cpu_pkg::pc_t     redirect_pc,
  input  logic             flush,
  input  cpu_pkg::inst_t   imem_data,
  output cpu_pkg::pc_t     imem_addr,
  output cpu_pkg::if_id_t  if_id
);

  cpu_pkg::pc_t pc;
  cpu_pkg::pc_t pc_next;

  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;  // taken transfer from execute
    end else if (stall) begin
      pc_next = pc;           // load-use or halt freeze
    end else begin
      pc_next = pc + 32'd4;   // static not-taken guess
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  assign imem_addr = pc;  // imem answers same cycle

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      if_id <= '0;  // zero word decodes as bubble
    end else if (!stall) begin
      if_id.inst <= imem_data;
      if_id.pc   <= pc;
    end
  end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::reg_idx_t rs1,
  input  cpu_pkg::reg_idx_t rs2,
  output cpu_pkg::word_t    rs1_data,
  output cpu_pkg::word_t    rs2_data,
  input  logic              wb_valid,
  input  cpu_pkg::reg_idx_t wb_rd,
  input  cpu_pkg::word_t    wb_data
);

  cpu_pkg::word_t regs [32];  // entry 0 never written

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // write-through so decode sees this cycle's commit
  assign rs1_data = (wb_valid && wb_rd == rs1 && rs1 != '0) ? wb_data : regs[rs1];
  assign rs2_data = (wb_valid && wb_rd == rs2 && rs2 != '0) ? wb_data : regs[rs2];

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::if_id_t   if_id,
  input  logic              bubble,
  input  logic              wb_valid,
  input  cpu_pkg::reg_idx_t wb_rd,
  input  cpu_pkg::word_t    wb_data,
  output cpu_pkg::reg_idx_t rs1_idx,
  output cpu_pkg::reg_idx_t rs2_idx,
  output cpu_pkg::id_ex_t   id_ex
);

  cpu_pkg::inst_t  inst;
  cpu_pkg::ctrl_t  ctrl;
  cpu_pkg::word_t  imm;
  cpu_pkg::word_t  rs1_data;
  cpu_pkg::word_t  rs2_data;
  cpu_pkg::id_ex_t id_next;

  assign inst = if_id.inst;

  // main control and immediate select
  always_comb begin
    ctrl = '0;  // unknown opcode -> nop
    imm  = '0;
    case (cpu_pkg::opcode_e'(inst[6:0]))
      cpu_pkg::opc_op: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_mode  = cpu_pkg::mode_reg;
      end
      cpu_pkg::opc_op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_mode  = cpu_pkg::mode_imm;
        imm = {{20{inst[31]}}, inst[31:20]};  // I
      end
      cpu_pkg::opc_load: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.alu_src   = 1'b1;               // base + offset
        ctrl.wb_sel    = cpu_pkg::wb_mem;
        imm = {{20{inst[31]}}, inst[31:20]};
      end
      cpu_pkg::opc_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};  // S
      end
      cpu_pkg::opc_branch: begin
        ctrl.alu_mode = cpu_pkg::mode_branch;
        ctrl.jump     = cpu_pkg::jump_branch;
        imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};  // B
      end
      cpu_pkg::opc_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = cpu_pkg::wb_pc4;
        ctrl.jump      = cpu_pkg::jump_jal;
        imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};  // J
      end
      cpu_pkg::opc_jalr: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.wb_sel    = cpu_pkg::wb_pc4;
        ctrl.jump      = cpu_pkg::jump_jalr;
        imm = {{20{inst[31]}}, inst[31:20]};
      end
      cpu_pkg::opc_system: ctrl.is_ecall = 1'b1;  // only ecall supported
      default: ;
    endcase
  end

  // ecall inspects a7 instead of its rs1 field
  assign rs1_idx = ctrl.is_ecall ? cpu_pkg::ecall_arg_reg : inst[19:15];
  assign rs2_idx = inst[24:20];

  reg_file rf_inst (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1_idx),
    .rs2      (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  always_comb begin
    id_next.ctrl     = ctrl;
    id_next.pc       = if_id.pc;
    id_next.rs1_data = rs1_data;
    id_next.rs2_data = rs2_data;
    id_next.imm      = imm;
    id_next.rs1      = rs1_idx;
    id_next.rs2      = rs2_idx;
    id_next.rd       = inst[11:7];
    id_next.funct3   = inst[14:12];
    id_next.funct7   = inst[30];  // sub / sra select
  end

  always_ff @(posedge clk) begin
    if (reset || bubble) begin
      id_ex <= '0;  // all control low
    end else begin
      id_ex <= id_next;
    end
  end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::id_ex_t   id_ex,
  input  logic [1:0]        fwd_a,
  input  logic [1:0]        fwd_b,
  input  cpu_pkg::word_t    mem_fwd,
  input  cpu_pkg::word_t    wb_data,
  output logic              redirect,
  output cpu_pkg::pc_t      redirect_pc,
  output logic              halt_req,
  output cpu_pkg::ex_mem_t  ex_mem
);

  cpu_pkg::word_t   op_a;
  cpu_pkg::word_t   op_b_reg;  // forwarded rs2, also store data
  cpu_pkg::word_t   alu_b;
  cpu_pkg::word_t   alu_res;
  cpu_pkg::word_t   jalr_sum;
  cpu_pkg::alu_op_e alu_op;
  cpu_pkg::pc_t     pc_plus4;
  logic             is_link;
  logic             cond;

  always_comb begin
    case (fwd_a)
      2'b10:   op_a = mem_fwd;  // from EX/MEM
      2'b01:   op_a = wb_data;  // from MEM/WB
      default: op_a = id_ex.rs1_data;
    endcase
    case (fwd_b)
      2'b10:   op_b_reg = mem_fwd;
      2'b01:   op_b_reg = wb_data;
      default: op_b_reg = id_ex.rs2_data;
    endcase
  end

  assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b_reg;

  // alu control
  always_comb begin
    alu_op = cpu_pkg::alu_add;
    case (id_ex.ctrl.alu_mode)
      cpu_pkg::mode_branch: begin
        case (id_ex.funct3[2:1])
          2'b10:   alu_op = cpu_pkg::alu_slt;   // blt / bge
          2'b11:   alu_op = cpu_pkg::alu_sltu;  // bltu / bgeu
          default: alu_op = cpu_pkg::alu_sub;   // beq / bne
        endcase
      end
      cpu_pkg::mode_reg, cpu_pkg::mode_imm: begin
        case (id_ex.funct3)
          3'b000: alu_op = (id_ex.funct7 && id_ex.ctrl.alu_mode == cpu_pkg::mode_reg) ?
                           cpu_pkg::alu_sub : cpu_pkg::alu_add;  // addi ignores bit 30
          3'b001: alu_op = cpu_pkg::alu_sll;
          3'b010: alu_op = cpu_pkg::alu_slt;
          3'b011: alu_op = cpu_pkg::alu_sltu;
          3'b100: alu_op = cpu_pkg::alu_xor;
          3'b101: alu_op = id_ex.funct7 ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
          3'b110: alu_op = cpu_pkg::alu_or;
          default: alu_op = cpu_pkg::alu_and;
        endcase
      end
      default: ;  // address arithmetic
    endcase
  end

  always_comb begin
    case (alu_op)
      cpu_pkg::alu_sub:  alu_res = op_a - alu_b;
      cpu_pkg::alu_sll:  alu_res = op_a << alu_b[4:0];
      cpu_pkg::alu_slt:  alu_res = cpu_pkg::word_t'($signed(op_a) < $signed(alu_b));
      cpu_pkg::alu_sltu: alu_res = cpu_pkg::word_t'(op_a < alu_b);
      cpu_pkg::alu_xor:  alu_res = op_a ^ alu_b;
      cpu_pkg::alu_srl:  alu_res = op_a >> alu_b[4:0];
      cpu_pkg::alu_sra:  alu_res = cpu_pkg::word_t'($signed(op_a) >>> alu_b[4:0]);
      cpu_pkg::alu_or:   alu_res = op_a | alu_b;
      cpu_pkg::alu_and:  alu_res = op_a & alu_b;
      default:           alu_res = op_a + alu_b;
    endcase
  end

  // funct3[2] picks compare vs equality, funct3[0] inverts
  assign cond = (id_ex.funct3[2] ? alu_res[0] : (alu_res == '0)) ^ id_ex.funct3[0];

  assign is_link  = id_ex.ctrl.jump == cpu_pkg::jump_jal || id_ex.ctrl.jump == cpu_pkg::jump_jalr;
  assign pc_plus4 = id_ex.pc + 32'd4;
  assign jalr_sum = op_a + id_ex.imm;

  assign redirect = is_link || (id_ex.ctrl.jump == cpu_pkg::jump_branch && cond);
  assign redirect_pc = (id_ex.ctrl.jump == cpu_pkg::jump_jalr) ?
                       {jalr_sum[31:1], 1'b0} : id_ex.pc + id_ex.imm;

  assign halt_req = id_ex.ctrl.is_ecall && op_a == cpu_pkg::halt_code;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem <= '0;
    end else begin
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.wb_sel     <= id_ex.ctrl.wb_sel;
      ex_mem.halt       <= halt_req;
      ex_mem.alu_out    <= is_link ? pc_plus4 : alu_res;  // link value forwards as-is
      ex_mem.store_data <= op_b_reg;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.pc         <= id_ex.pc;
    end
  end

endmodule

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::id_ex_t   id_ex,
  input  cpu_pkg::reg_idx_t rs1_idx,
  input  cpu_pkg::reg_idx_t rs2_idx,
  input  cpu_pkg::ex_mem_t  ex_mem,
  input  cpu_pkg::mem_wb_t  mem_wb,
  input  logic              redirect,
  input  logic              halt_req,
  output logic              stall,
  output logic              flush_if_id,
  output logic              bubble_id_ex,
  output logic [1:0]        fwd_a,
  output logic [1:0]        fwd_b
);

  logic frozen;    // set by halting ecall
  logic load_use;

  // newest producer wins
  function automatic logic [1:0] fwd_sel(cpu_pkg::reg_idx_t src, cpu_pkg::ex_mem_t em,
                                         cpu_pkg::mem_wb_t mw);
    if (em.reg_write && em.rd != '0 && em.rd == src) return 2'b10;
    if (mw.reg_write && mw.rd != '0 && mw.rd == src) return 2'b01;
    return 2'b00;
  endfunction

  assign fwd_a = fwd_sel(id_ex.rs1, ex_mem, mem_wb);
  assign fwd_b = fwd_sel(id_ex.rs2, ex_mem, mem_wb);

  assign load_use = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
                    (id_ex.rd == rs1_idx || id_ex.rd == rs2_idx);

  always_ff @(posedge clk) begin
    if (reset) begin
      frozen <= 1'b0;
    end else if (halt_req) begin
      frozen <= 1'b1;  // held until reset
    end
  end

  assign stall        = load_use || halt_req || frozen;
  assign flush_if_id  = redirect || halt_req || frozen;
  assign bubble_id_ex = load_use || redirect || halt_req || frozen;

endmodule

// ==== hdl/mem_wb_stage.sv ====
`timescale 1ns/1ps

module mem_wb_stage (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::ex_mem_t  ex_mem,
  output cpu_pkg::mem_wb_t  mem_wb,
  output logic              wb_valid,
  output cpu_pkg::reg_idx_t wb_rd,
  output cpu_pkg::word_t    wb_data,
  output logic              is_halted
);

  cpu_pkg::word_t      dmem [cpu_pkg::dmem_depth];
  cpu_pkg::dmem_addr_t dmem_addr;
  cpu_pkg::word_t      mem_data;
  logic                halted;

  assign dmem_addr = ex_mem.alu_out[9:2];  // word aligned only
  assign mem_data  = dmem[dmem_addr];        // async read

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < cpu_pkg::dmem_depth; i++) begin
        dmem[i] <= '0;
      end
    end else if (ex_mem.mem_write) begin
      dmem[dmem_addr] <= ex_mem.store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb <= '0;
    end else begin
      mem_wb.reg_write <= ex_mem.reg_write;
      mem_wb.wb_sel    <= ex_mem.wb_sel;
      mem_wb.halt      <= ex_mem.halt;
      mem_wb.alu_out   <= ex_mem.alu_out;
      mem_wb.mem_data  <= mem_data;
      mem_wb.rd        <= ex_mem.rd;
      mem_wb.pc        <= ex_mem.pc;
    end
  end

  always_comb begin
    case (mem_wb.wb_sel)
      cpu_pkg::wb_mem: wb_data = mem_wb.mem_data;
      cpu_pkg::wb_pc4: wb_data = mem_wb.pc + 32'd4;  // link address
      default:         wb_data = mem_wb.alu_out;
    endcase
  end

  assign wb_valid = mem_wb.reg_write && mem_wb.rd != '0;  // x0 writes are not commits
  assign wb_rd    = mem_wb.rd;

  always_ff @(posedge clk) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (mem_wb.halt) begin
      halted <= 1'b1;
    end
  end

  assign is_halted = halted || mem_wb.halt;  // high from the ecall's wb cycle on

endmodule

// ==== hdl/cpu.sv ====
`timescale 1ns/1ps

module cpu (
  input  logic              clk,
  input  logic              reset,
  output cpu_pkg::pc_t      imem_addr,
  input  cpu_pkg::inst_t    imem_data,
  output logic              is_halted,
  output logic              wb_valid,
  output cpu_pkg::reg_idx_t wb_rd,
  output cpu_pkg::word_t    wb_data
);

  cpu_pkg::if_id_t   if_id;
  cpu_pkg::id_ex_t   id_ex;
  cpu_pkg::ex_mem_t  ex_mem;
  cpu_pkg::mem_wb_t  mem_wb;
  cpu_pkg::pc_t      redirect_pc;
  cpu_pkg::reg_idx_t rs1_idx;
  cpu_pkg::reg_idx_t rs2_idx;
  logic              redirect;
  logic              halt_req;
  logic              stall;
  logic              flush_if_id;
  logic              bubble_id_ex;
  logic [1:0]        fwd_a;
  logic [1:0]        fwd_b;

  fetch_stage fetch_inst (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .flush       (flush_if_id),
    .imem_data   (imem_data),
    .imem_addr   (imem_addr),
    .if_id       (if_id)
  );

  decode_stage decode_inst (
    .clk      (clk),
    .reset    (reset),
    .if_id    (if_id),
    .bubble   (bubble_id_ex),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .id_ex    (id_ex)
  );

  execute_stage execute_inst (
    .clk         (clk),
    .reset       (reset),
    .id_ex       (id_ex),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b),
    .mem_fwd     (ex_mem.alu_out),  // mem-stage result
    .wb_data     (wb_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halt_req    (halt_req),
    .ex_mem      (ex_mem)
  );

  hazard_unit hazard_inst (
    .clk          (clk),
    .reset        (reset),
    .id_ex        (id_ex),
    .rs1_idx      (rs1_idx),
    .rs2_idx      (rs2_idx),
    .ex_mem       (ex_mem),
    .mem_wb       (mem_wb),
    .redirect     (redirect),
    .halt_req     (halt_req),
    .stall        (stall),
    .flush_if_id  (flush_if_id),
    .bubble_id_ex (bubble_id_ex),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b)
  );

  mem_wb_stage mem_wb_inst (
    .clk       (clk),
    .reset     (reset),
    .ex_mem    (ex_mem),
    .mem_wb    (mem_wb),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .is_halted (is_halted)
  );

endmodule

// ==== verif/cpu_tb_prog.svh ====
`ifndef cpu_tb_prog_svh
`define cpu_tb_prog_svh

function automatic cpu_pkg::inst_t r_type(logic [6:0] f7, cpu_pkg::reg_idx_t rs2,
                                          cpu_pkg::reg_idx_t rs1, logic [2:0] f3,
                                          cpu_pkg::reg_idx_t rd);
  return {f7, rs2, rs1, f3, rd, cpu_pkg::opc_op};
endfunction

function automatic cpu_pkg::inst_t i_type(logic [11:0] imm, cpu_pkg::reg_idx_t rs1,
                                          logic [2:0] f3, cpu_pkg::reg_idx_t rd,
                                          logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic cpu_pkg::inst_t s_type(logic [11:0] imm, cpu_pkg::reg_idx_t rs2,
                                          cpu_pkg::reg_idx_t rs1, logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], cpu_pkg::opc_store};
endfunction

function automatic cpu_pkg::inst_t b_type(logic [12:0] imm, cpu_pkg::reg_idx_t rs2,
                                          cpu_pkg::reg_idx_t rs1, logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpu_pkg::opc_branch};
endfunction

function automatic cpu_pkg::inst_t j_type(logic [20:0] imm, cpu_pkg::reg_idx_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpu_pkg::opc_jal};
endfunction

function automatic cpu_pkg::inst_t nop_word();
  return i_type(12'd0, 5'd0, 3'b000, 5'd0, cpu_pkg::opc_op_imm);  // addi x0, x0, 0
endfunction

task automatic emit(cpu_pkg::inst_t inst);
  prog_q.push_back(inst);  // next word address = size * 4
endtask

task automatic expect_commit(cpu_pkg::reg_idx_t rd, cpu_pkg::word_t value);
  commit_t c;
  c.rd    = rd;
  c.value = value;
  exp_q.push_back(c);
  exp_name_q.push_back(test_name);  // group label for error lines
endtask

task automatic alu_r(logic [6:0] f7, logic [2:0] f3, cpu_pkg::reg_idx_t rd,
                     cpu_pkg::reg_idx_t rs1, cpu_pkg::reg_idx_t rs2, cpu_pkg::word_t value);
  emit(r_type(f7, rs2, rs1, f3, rd));
  expect_commit(rd, value);
endtask

task automatic alu_i(logic [2:0] f3, cpu_pkg::reg_idx_t rd, cpu_pkg::reg_idx_t rs1,
                     logic [11:0] imm, cpu_pkg::word_t value);
  emit(i_type(imm, rs1, f3, rd, cpu_pkg::opc_op_imm));
  expect_commit(rd, value);
endtask

task automatic load_word(cpu_pkg::reg_idx_t rd, cpu_pkg::reg_idx_t rs1, logic [11:0] imm,
                         cpu_pkg::word_t value);
  emit(i_type(imm, rs1, 3'b010, rd, cpu_pkg::opc_load));
  expect_commit(rd, value);
endtask

// x31 marker never appears in the expected table
task automatic emit_shadow(int n);
  repeat (n) emit(i_type(12'h0bd, 5'd0, 3'b000, 5'd31, cpu_pkg::opc_op_imm));
endtask

task automatic skip_branch(logic [2:0] f3, cpu_pkg::reg_idx_t rs1, cpu_pkg::reg_idx_t rs2);
  emit(b_type(13'd12, rs2, rs1, f3));  // lands past both markers
  emit_shadow(2);
endtask

task automatic fall_branch(logic [2:0] f3, cpu_pkg::reg_idx_t rs1, cpu_pkg::reg_idx_t rs2);
  fall_count++;
  emit(b_type(13'd8, rs2, rs1, f3));  // a wrong take skips the count
  alu_i(3'b000, 5'd28, 5'd28, 12'd1, fall_count);
endtask

task automatic load_program();
  int base;
  test_name = "alu";
  alu_i(3'b000, 5'd1, 5'd0, 12'd5, 32'd5);               // addi x1 = 5
  alu_i(3'b000, 5'd2, 5'd1, 12'hff4, 32'hffff_fff9);     // addi x2 = x1 - 12
  alu_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2, 32'hffff_fffe); // add with x2 from mem stage
  alu_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd1, 32'hffff_fff9); // sub
  alu_r(7'h00, 3'b001, 5'd5, 5'd4, 5'd1, 32'hffff_ff20); // sll by 5
  alu_r(7'h00, 3'b010, 5'd6, 5'd4, 5'd1, 32'd1);         // slt -7 < 5
  alu_r(7'h00, 3'b011, 5'd7, 5'd4, 5'd1, 32'd0);         // sltu big < 5
  alu_r(7'h00, 3'b100, 5'd8, 5'd5, 5'd3, 32'h0000_00de); // xor
  alu_r(7'h00, 3'b101, 5'd9, 5'd4, 5'd1, 32'h07ff_ffff); // srl
  alu_r(7'h20, 3'b101, 5'd10, 5'd4, 5'd1, 32'hffff_ffff); // sra
  alu_r(7'h00, 3'b110, 5'd11, 5'd8, 5'd1, 32'h0000_00df); // or
  alu_r(7'h00, 3'b111, 5'd12, 5'd11, 5'd3, 32'h0000_00de); // and
  alu_i(3'b001, 5'd13, 5'd1, 12'd3, 32'd40);             // slli
  alu_i(3'b010, 5'd14, 5'd2, 12'hffa, 32'd1);            // slti -7 < -6
  alu_i(3'b011, 5'd15, 5'd1, 12'hfff, 32'd1);            // sltiu against all ones
  alu_i(3'b100, 5'd16, 5'd13, 12'h0ff, 32'h0000_00d7);   // xori
  alu_i(3'b101, 5'd18, 5'd4, 12'd28, 32'h0000_000f);     // srli
  alu_i(3'b101, 5'd19, 5'd4, 12'h401, 32'hffff_fffc);    // srai
  alu_i(3'b110, 5'd20, 5'd1, 12'h700, 32'h0000_0705);    // ori
  alu_i(3'b111, 5'd21, 5'd20, 12'h7f0, 32'h0000_0700);   // andi
  alu_i(3'b000, 5'd21, 5'd21, 12'd1, 32'h0000_0701);     // x21 rewritten at once
  alu_r(7'h00, 3'b000, 5'd12, 5'd21, 5'd0, 32'h0000_0701); // newer x21 in mem stage wins
  test_name = "mem";
  alu_i(3'b000, 5'd22, 5'd0, 12'd64, 32'd64);            // base address
  emit(s_type(12'd4, 5'd5, 5'd22, 3'b010));              // sw x5, 4(x22)
  load_word(5'd23, 5'd22, 12'd4, 32'hffff_ff20);         // read back the store
  alu_r(7'h00, 3'b000, 5'd24, 5'd23, 5'd1, 32'hffff_ff25); // load-use on rs1
  emit(s_type(12'd0, 5'd24, 5'd22, 3'b010));             // store data forwarded
  load_word(5'd25, 5'd22, 12'd0, 32'hffff_ff25);
  load_word(5'd26, 5'd22, 12'd8, 32'd0);                 // untouched word
  alu_r(7'h20, 3'b000, 5'd27, 5'd25, 5'd26, 32'hffff_ff25); // load-use on rs2
  test_name = "branch";
  skip_branch(3'b000, 5'd1, 5'd1);  // beq
  fall_branch(3'b000, 5'd1, 5'd2);
  skip_branch(3'b001, 5'd1, 5'd2);  // bne
  fall_branch(3'b001, 5'd1, 5'd1);
  skip_branch(3'b100, 5'd2, 5'd1);  // blt
  fall_branch(3'b100, 5'd1, 5'd2);
  skip_branch(3'b101, 5'd1, 5'd2);  // bge
  skip_branch(3'b101, 5'd1, 5'd1);  // bge on equal
  fall_branch(3'b101, 5'd2, 5'd1);
  skip_branch(3'b110, 5'd1, 5'd2);  // bltu
  fall_branch(3'b110, 5'd2, 5'd1);
  skip_branch(3'b111, 5'd2, 5'd1);  // bgeu
  fall_branch(3'b111, 5'd1, 5'd2);
  test_name = "jump";
  base = prog_q.size() * 4;
  emit(j_type(21'd12, 5'd29));      // jal x29, +12
  expect_commit(5'd29, base + 4);
  emit_shadow(2);
  base = prog_q.size() * 4;         // jalr sits at base + 4
  alu_i(3'b000, 5'd30, 5'd0, 12'(base + 16), base + 16);
  emit(i_type(12'd1, 5'd30, 3'b000, 5'd26, cpu_pkg::opc_jalr));  // odd sum drops bit 0
  expect_commit(5'd26, base + 8);
  emit_shadow(2);
  test_name = "ecall";
  alu_i(3'b000, 5'd17, 5'd0, 12'd3, 32'd3);
  emit(i_type(12'd0, 5'd0, 3'b000, 5'd0, cpu_pkg::opc_system));  // not a halt
  fall_count++;
  alu_i(3'b000, 5'd28, 5'd28, 12'd1, fall_count);
  alu_i(3'b000, 5'd17, 5'd0, 12'd10, 32'd10);
  emit(i_type(12'd0, 5'd0, 3'b000, 5'd0, cpu_pkg::opc_system));  // halt
  emit_shadow(2);
endtask

`endif

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

  typedef struct packed {
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::word_t    value;
  } commit_t;

  logic              clk = 1'b0;
  logic              reset;
  cpu_pkg::pc_t      imem_addr;
  cpu_pkg::inst_t    imem_data;
  logic              is_halted;
  logic              wb_valid;
  cpu_pkg::reg_idx_t wb_rd;
  cpu_pkg::word_t    wb_data;

  cpu_pkg::inst_t prog_q [$];      // word-indexed program
  commit_t        exp_q [$];       // commits in retire order
  string          exp_name_q [$];
  string          test_name;
  int             fall_count;      // running x28 value
  int             commit_idx;
  int             cycle_count;
  int             max_cycles;

  `include "cpu_tb_prog.svh"

  cpu cpu_inst (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .is_halted (is_halted),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  always #5 clk = ~clk;  // 10 ns period

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(string name, cpu_pkg::word_t exp, cpu_pkg::word_t act);
    assert (act === exp)
      else fail_run($sformatf("[ERROR] %s: expected %h actual %h", name, exp, act));
  endtask

  function automatic cpu_pkg::inst_t fetch_word(cpu_pkg::pc_t addr);
    if (addr[31:2] < prog_q.size()) begin
      return prog_q[addr[31:2]];
    end
    return nop_word();  // past the end or unknown
  endfunction

  // imem model settles well before the fetch edge
  always @(negedge clk) begin
    assert (imem_addr[1:0] == 2'b00)
      else fail_run("fetch address is not word aligned");
    imem_data <= fetch_word(imem_addr);
  end

  // in-order commit compare
  always @(negedge clk) begin
    if (wb_valid) begin
      assert (!is_halted) else fail_run("an instruction committed after the halt");
      assert (commit_idx < exp_q.size())
        else fail_run("more commits than the expected table holds");
      check_eq($sformatf("%s commit %0d rd", exp_name_q[commit_idx], commit_idx),
               exp_q[commit_idx].rd, wb_rd);
      check_eq($sformatf("%s commit %0d data", exp_name_q[commit_idx], commit_idx),
               exp_q[commit_idx].value, wb_data);
      commit_idx++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > max_cycles) begin
      fail_run($sformatf("timeout with no halt after %0d cycles", max_cycles));
    end
  end

  initial begin
    reset = 1'b1;
    imem_data = nop_word();
    load_program();
    max_cycles = 3 * prog_q.size() + 60;  // 3 cycles worst case per word plus reset and hold
    repeat (5) begin
      @(negedge clk);
      check_eq("reset wb_valid", 32'd0, wb_valid);
      check_eq("reset is_halted", 32'd0, is_halted);
      check_eq("reset imem_addr", 32'd0, imem_addr);
    end
    reset <= 1'b0;
    @(negedge clk);
    check_eq("first cycle wb_valid", 32'd0, wb_valid);
    check_eq("first cycle is_halted", 32'd0, is_halted);
    check_eq("first cycle imem_addr", 32'd4, imem_addr);  // one step past 0
    while (!is_halted) begin
      @(negedge clk);
    end
    repeat (10) begin
      @(negedge clk);
      check_eq("halt hold", 32'd1, is_halted);
    end
    if (commit_idx == exp_q.size()) begin
      $display("sim passed");
      $finish;
    end else begin
      fail_run($sformatf("halted after %0d of %0d expected commits",
                         commit_idx, exp_q.size()));
    end
  end

endmodule

// ==== files.f ====
+incdir+verif
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/hazard_unit.sv
hdl/mem_wb_stage.sv
hdl/cpu.sv
verif/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_pipeline

sources:
  - hdl/cpu_pkg.sv
  - hdl/fetch_stage.sv
  - hdl/reg_file.sv
  - hdl/decode_stage.sv
  - hdl/execute_stage.sv
  - hdl/hazard_unit.sv
  - hdl/mem_wb_stage.sv
  - hdl/cpu.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/cpu_tb.sv
